// File: rtl/alu_core.sv
`default_nettype none

module alu_core (
        input  wire                    clk,
        input  wire                    rst_n,
        input  wire core_pkg::word_t   ibus_rddata_i,
        input  wire                    ibus_stall_i,
        output core_pkg::word_t        ibus_addr_o,
        output logic                   ibus_read_o,
        output logic                   wb_we_o,
        output core_pkg::reg_idx_t     wb_addr_o,
        output core_pkg::word_t        wb_data_o
);

        core_pkg::word_t    inst;
        logic               inst_valid;
        core_pkg::alu_op_e  alu_op;
        core_pkg::reg_idx_t rs_idx;
        core_pkg::reg_idx_t rt_idx;
        core_pkg::reg_idx_t rd_idx;
        logic               use_imm;
        core_pkg::word_t    imm;
        core_pkg::word_t    rs_val;
        core_pkg::word_t    rt_val;
        logic               ex_we;
        core_pkg::reg_idx_t ex_idx;
        core_pkg::word_t    ex_val;

        fetch_unit u_fetch (
                .clk           (clk),
                .rst_n         (rst_n),
                .ibus_stall_i  (ibus_stall_i),
                .ibus_rddata_i (ibus_rddata_i),
                .ibus_addr_o   (ibus_addr_o),
                .ibus_read_o   (ibus_read_o),
                .inst_o        (inst),
                .inst_valid_o  (inst_valid)
        );

        // decode and operand read run side by side on the same word.
        inst_decode u_decode (
                .inst_i    (inst),
                .alu_op_o  (alu_op),
                .rs_o      (rs_idx),
                .rt_o      (rt_idx),
                .rd_o      (rd_idx),
                .use_imm_o (use_imm),
                .imm_o     (imm)
        );

        operand_fetch u_operands (
                .clk      (clk),
                .rst_n    (rst_n),
                .rs_i     (rs_idx),
                .rt_i     (rt_idx),
                .ex_we_i  (ex_we),
                .ex_idx_i (ex_idx),
                .ex_val_i (ex_val),
                .wb_we_i  (wb_we_o),
                .wb_idx_i (wb_addr_o),
                .wb_val_i (wb_data_o),
                .rs_val_o (rs_val),
                .rt_val_o (rt_val)
        );

        alu_exec u_exec (
                .clk       (clk),
                .rst_n     (rst_n),
                .valid_i   (inst_valid),
                .alu_op_i  (alu_op),
                .rd_i      (rd_idx),
                .use_imm_i (use_imm),
                .imm_i     (imm),
                .rs_val_i  (rs_val),
                .rt_val_i  (rt_val),
                .ex_we_o   (ex_we),
                .ex_idx_o  (ex_idx),
                .ex_val_o  (ex_val),
                .wb_we_o   (wb_we_o),
                .wb_addr_o (wb_addr_o),
                .wb_data_o (wb_data_o)
        );

endmodule

`default_nettype wire

// File: rtl/alu_exec.sv
`include "core_defs.svh"
`default_nettype none

module alu_exec (
        input  wire                        clk,
        input  wire                        rst_n,
        input  wire                        valid_i,
        input  wire core_pkg::alu_op_e     alu_op_i,
        input  wire core_pkg::reg_idx_t    rd_i,
        input  wire                        use_imm_i,
        input  wire core_pkg::word_t       imm_i,
        input  wire core_pkg::word_t       rs_val_i,
        input  wire core_pkg::word_t       rt_val_i,
        output logic                       ex_we_o,
        output core_pkg::reg_idx_t         ex_idx_o,
        output core_pkg::word_t            ex_val_o,
        output logic                       wb_we_o,
        output core_pkg::reg_idx_t         wb_addr_o,
        output core_pkg::word_t            wb_data_o
);

        logic               valid_q;
        core_pkg::alu_op_e  op_q;
        core_pkg::reg_idx_t rd_q;
        logic               use_imm_q;
        core_pkg::word_t    imm_q;
        core_pkg::word_t    rs_val_q;
        core_pkg::word_t    rt_val_q;
        core_pkg::word_t    opb;
        core_pkg::word_t    result;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        valid_q <= 1'b0;
                        wb_we_o <= 1'b0;
                end else begin
                        valid_q <= valid_i;
                        wb_we_o <= ex_we_o;
                end
        end

        always_ff @(posedge clk) begin
                op_q      <= alu_op_i;
                rd_q      <= rd_i;
                use_imm_q <= use_imm_i;
                imm_q     <= imm_i;
                rs_val_q  <= rs_val_i;
                rt_val_q  <= rt_val_i;
                wb_addr_o <= ex_idx_o;
                wb_data_o <= ex_val_o;
        end

        assign opb = use_imm_q ? imm_q : rt_val_q;

        always_comb begin
                case (op_q)
                core_pkg::ALU_ADD:  result = rs_val_q + opb;
                core_pkg::ALU_SUB:  result = rs_val_q - opb;
                core_pkg::ALU_AND:  result = rs_val_q & opb;
                core_pkg::ALU_OR:   result = rs_val_q | opb;
                core_pkg::ALU_XOR:  result = rs_val_q ^ opb;
                core_pkg::ALU_NOR:  result = ~(rs_val_q | opb);
                core_pkg::ALU_SLT:  result = {31'b0, $signed(rs_val_q) < $signed(opb)};
                core_pkg::ALU_SLTU: result = {31'b0, rs_val_q < opb};
                core_pkg::ALU_LUI:  result = {opb[15:0], 16'b0};
                default:            result = '0;
                endcase
        end

        // bubbles, unknown encodings and r0 targets retire nothing.
        assign ex_we_o  = valid_q && (op_q != core_pkg::ALU_NOP) && (rd_q != '0);
        assign ex_idx_o = rd_q;
        assign ex_val_o = result;

        a_wb_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
                wb_we_o |-> wb_addr_o != '0);

endmodule

`default_nettype wire

// File: rtl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and register file geometry.
`define CORE_XLEN       32
`define CORE_NREGS      32
`define CORE_PC_STEP    32'd4

// primary opcodes.
`define OPC_SPECIAL     6'h00
`define OPC_ADDIU       6'h09
`define OPC_SLTI        6'h0a
`define OPC_ANDI        6'h0c
`define OPC_ORI         6'h0d
`define OPC_XORI        6'h0e
`define OPC_LUI         6'h0f

// funct field of SPECIAL.
`define FN_ADDU         6'h21
`define FN_SUBU         6'h23
`define FN_AND          6'h24
`define FN_OR           6'h25
`define FN_XOR          6'h26
`define FN_NOR          6'h27
`define FN_SLT          6'h2a
`define FN_SLTU         6'h2b

`endif

// File: rtl/core_pkg.sv
`include "core_defs.svh"
`default_nettype none

package core_pkg;

        // data word, also used for instruction addresses.
        typedef logic [`CORE_XLEN-1:0] word_t;

        typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

        // raw 16-bit immediate field of an I-type word.
        typedef logic [15:0] imm_t;

        typedef enum logic [3:0] {
                ALU_NOP,
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_NOR,
                ALU_SLT,
                ALU_SLTU,
                ALU_LUI
        } alu_op_e;

endpackage

`default_nettype wire

// File: rtl/fetch_unit.sv
`include "core_defs.svh"
`default_nettype none

module fetch_unit (
        input  wire                    clk,
        input  wire                    rst_n,
        input  wire                    ibus_stall_i,
        input  wire core_pkg::word_t   ibus_rddata_i,
        output core_pkg::word_t        ibus_addr_o,
        output logic                   ibus_read_o,
        output core_pkg::word_t        inst_o,
        output logic                   inst_valid_o
);

        core_pkg::word_t pc_q;
        core_pkg::word_t inst_q;
        logic            read_q;
        logic            accept;

        // a fetch completes when the bus is read and not stalled.
        assign accept = read_q && !ibus_stall_i;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        pc_q         <= '0;
                        read_q       <= 1'b0;
                        inst_valid_o <= 1'b0;
                end else begin
                        read_q       <= 1'b1;
                        inst_valid_o <= accept;
                        if (accept) begin
                                pc_q <= pc_q + `CORE_PC_STEP;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (accept) begin
                        inst_q <= ibus_rddata_i;
                end
        end

        assign ibus_addr_o = pc_q;
        assign ibus_read_o = read_q;
        assign inst_o      = inst_q;

        // only sequential steps, so the pc never leaves word alignment.
        a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
                pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rtl/inst_decode.sv
`include "core_defs.svh"
`default_nettype none

module inst_decode (
        input  wire core_pkg::word_t   inst_i,
        output core_pkg::alu_op_e      alu_op_o,
        output core_pkg::reg_idx_t     rs_o,
        output core_pkg::reg_idx_t     rt_o,
        output core_pkg::reg_idx_t     rd_o,
        output logic                   use_imm_o,
        output core_pkg::word_t        imm_o
);

        logic [5:0]      opcode;
        logic [5:0]      funct;
        core_pkg::imm_t  imm_raw;
        core_pkg::word_t imm_sext;
        core_pkg::word_t imm_zext;

        assign opcode  = inst_i[31:26];
        assign funct   = inst_i[5:0];
        assign imm_raw = inst_i[15:0];
        assign rs_o    = inst_i[25:21];
        assign rt_o    = inst_i[20:16];

        assign imm_sext = {{(`CORE_XLEN-16){imm_raw[15]}}, imm_raw};
        assign imm_zext = {{(`CORE_XLEN-16){1'b0}}, imm_raw};

        // I-type by default, SPECIAL overrides destination and operand b.
        always_comb begin
                alu_op_o  = core_pkg::ALU_NOP;
                rd_o      = inst_i[20:16];
                use_imm_o = 1'b1;
                imm_o     = imm_zext;
                case (opcode)
                `OPC_SPECIAL: begin
                        rd_o      = inst_i[15:11];
                        use_imm_o = 1'b0;
                        case (funct)
                        `FN_ADDU: alu_op_o = core_pkg::ALU_ADD;
                        `FN_SUBU: alu_op_o = core_pkg::ALU_SUB;
                        `FN_AND:  alu_op_o = core_pkg::ALU_AND;
                        `FN_OR:   alu_op_o = core_pkg::ALU_OR;
                        `FN_XOR:  alu_op_o = core_pkg::ALU_XOR;
                        `FN_NOR:  alu_op_o = core_pkg::ALU_NOR;
                        `FN_SLT:  alu_op_o = core_pkg::ALU_SLT;
                        `FN_SLTU: alu_op_o = core_pkg::ALU_SLTU;
                        default:  alu_op_o = core_pkg::ALU_NOP;
                        endcase
                end
                `OPC_ADDIU: begin
                        alu_op_o = core_pkg::ALU_ADD;
                        imm_o    = imm_sext;
                end
                `OPC_SLTI: begin
                        alu_op_o = core_pkg::ALU_SLT;
                        imm_o    = imm_sext;
                end
                `OPC_ANDI: alu_op_o = core_pkg::ALU_AND;
                `OPC_ORI:  alu_op_o = core_pkg::ALU_OR;
                `OPC_XORI: alu_op_o = core_pkg::ALU_XOR;
                `OPC_LUI:  alu_op_o = core_pkg::ALU_LUI;
                default:   alu_op_o = core_pkg::ALU_NOP;
                endcase
        end

endmodule

`default_nettype wire

// File: rtl/operand_fetch.sv
`include "core_defs.svh"
`default_nettype none

module operand_fetch (
        input  wire                        clk,
        input  wire                        rst_n,
        input  wire core_pkg::reg_idx_t    rs_i,
        input  wire core_pkg::reg_idx_t    rt_i,
        input  wire                        ex_we_i,
        input  wire core_pkg::reg_idx_t    ex_idx_i,
        input  wire core_pkg::word_t       ex_val_i,
        input  wire                        wb_we_i,
        input  wire core_pkg::reg_idx_t    wb_idx_i,
        input  wire core_pkg::word_t       wb_val_i,
        output core_pkg::word_t            rs_val_o,
        output core_pkg::word_t            rt_val_o
);

        core_pkg::word_t regs_q [`CORE_NREGS];

        // newest producer wins: execute, then writeback, then the array.
        function automatic core_pkg::word_t resolve(input core_pkg::reg_idx_t idx);
                core_pkg::word_t val;
                if (idx == '0) begin
                        val = '0;
                end else if (ex_we_i && ex_idx_i == idx) begin
                        val = ex_val_i;
                end else if (wb_we_i && wb_idx_i == idx) begin
                        val = wb_val_i;
                end else begin
                        val = regs_q[idx];
                end
                return val;
        endfunction

        always_comb begin
                rs_val_o = resolve(rs_i);
                rt_val_o = resolve(rt_i);
        end

        // write lands at the edge that closes the writeback cycle.
        always_ff @(posedge clk) begin
                if (wb_we_i) begin
                        regs_q[wb_idx_i] <= wb_val_i;
                end
        end

        // r0 reads as zero, so nothing upstream may try to store into it.
        a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
                wb_we_i |-> wb_idx_i != '0);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_alu_core \
        -Mdir obj_dir -o sim_alu_core
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

./obj_dir/sim_alu_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "Test completed successfully" sim.log; then
        exit 0
fi
exit 1

// File: sim/tb_alu_core.sv
`include "core_defs.svh"
`default_nettype none

module tb_alu_core;

        localparam int NUM_INSTS      = 2000;
        localparam int TIMEOUT_CYCLES = NUM_INSTS * 4 + 100;

        logic                clk;
        logic                rst_n;
        core_pkg::word_t     ibus_rddata_i;
        logic                ibus_stall_i;
        core_pkg::word_t     ibus_addr_o;
        logic                ibus_read_o;
        logic                wb_we_o;
        core_pkg::reg_idx_t  wb_addr_o;
        core_pkg::word_t     wb_data_o;

        logic [31:0]         lfsr_q;
        core_pkg::word_t     mregs [`CORE_NREGS];
        core_pkg::reg_idx_t  exp_addr [$];
        core_pkg::word_t     exp_data [$];
        core_pkg::word_t     fetch_ptr;
        core_pkg::word_t     cur_inst;
        int                  fetched;
        int                  cycles;

        alu_core dut0 (
                .clk           (clk),
                .rst_n         (rst_n),
                .ibus_rddata_i (ibus_rddata_i),
                .ibus_stall_i  (ibus_stall_i),
                .ibus_addr_o   (ibus_addr_o),
                .ibus_read_o   (ibus_read_o),
                .wb_we_o       (wb_we_o),
                .wb_addr_o     (wb_addr_o),
                .wb_data_o     (wb_data_o)
        );

        always #2 clk = ~clk;

        task automatic report_failure(input string msg);
                $display("%s", msg);
                $display("Test failed");
                $fatal(1);
        endtask

        // fibonacci lfsr with taps 32 22 2 1 that steps once per bit taken.
        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] val;
                logic        fb;
                int          i;
                val = '0;
                for (i = 0; i < n; i++) begin
                        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
                        lfsr_q = {lfsr_q[30:0], fb};
                        val    = {val[30:0], fb};
                end
                return val;
        endfunction

        // mostly r0..r7, so back-to-back dependencies are common.
        function automatic core_pkg::reg_idx_t pick_reg();
                logic [31:0] r;
                r = rand_bits(2);
                if (r[1:0] != 2'b00) begin
                        r = rand_bits(3);
                end else begin
                        r = rand_bits(5);
                end
                return r[4:0];
        endfunction

        function automatic logic draw_stall();
                logic [31:0] r;
                r = rand_bits(2);
                return r[1:0] == 2'b00;
        endfunction

        function automatic core_pkg::word_t gen_inst(input core_pkg::word_t pc);
                logic [31:0]        cls;
                logic [31:0]        imm;
                logic [31:0]        junk;
                core_pkg::reg_idx_t rs;
                core_pkg::reg_idx_t rt;
                core_pkg::reg_idx_t rd;
                logic [5:0]         code;
                core_pkg::word_t    inst;
                imm = rand_bits(16);
                // the first words give r1..r31 a known value with ori from r0.
                if (pc[31:2] < 30'(`CORE_NREGS - 1)) begin
                        return {`OPC_ORI, 5'd0, pc[6:2] + 5'd1, imm[15:0]};
                end
                cls = rand_bits(4);
                rs  = pick_reg();
                rt  = pick_reg();
                rd  = pick_reg();
                case (cls[3:0])
                4'd1:    code = `FN_ADDU;
                4'd2:    code = `FN_SUBU;
                4'd3:    code = `FN_AND;
                4'd4:    code = `FN_OR;
                4'd5:    code = `FN_XOR;
                4'd6:    code = `FN_NOR;
                4'd7:    code = `FN_SLT;
                4'd8:    code = `FN_SLTU;
                4'd9:    code = `OPC_SLTI;
                4'd10:   code = `OPC_ANDI;
                4'd11:   code = `OPC_ORI;
                4'd12:   code = `OPC_XORI;
                4'd13:   code = `OPC_LUI;
                default: code = `OPC_ADDIU;
                endcase
                if (cls[3:0] == 4'd0) begin
                        // opcode 3f and SPECIAL funct 0 are both outside the subset.
                        junk = rand_bits(21);
                        inst = {(junk[20] ? 6'h3f : `OPC_SPECIAL), junk[19:0], 6'h00};
                end else if (cls[3:0] <= 4'd8) begin
                        inst = {`OPC_SPECIAL, rs, rt, rd, 5'd0, code};
                end else begin
                        inst = {code, rs, rt, imm[15:0]};
                end
                return inst;
        endfunction

        // in-order reference model with mips semantics on a private register array.
        task automatic model_exec(input core_pkg::word_t inst);
                core_pkg::word_t    a;
                core_pkg::word_t    b;
                core_pkg::word_t    sext;
                core_pkg::word_t    zext;
                core_pkg::word_t    val;
                core_pkg::reg_idx_t dst;
                logic               known;
                a     = mregs[inst[25:21]];
                b     = mregs[inst[20:16]];
                sext  = {{16{inst[15]}}, inst[15:0]};
                zext  = {16'h0, inst[15:0]};
                dst   = inst[20:16];
                known = 1'b1;
                val   = '0;
                case (inst[31:26])
                `OPC_SPECIAL: begin
                        dst = inst[15:11];
                        case (inst[5:0])
                        `FN_ADDU: val = a + b;
                        `FN_SUBU: val = a - b;
                        `FN_AND:  val = a & b;
                        `FN_OR:   val = a | b;
                        `FN_XOR:  val = a ^ b;
                        `FN_NOR:  val = ~(a | b);
                        `FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        `FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
                        default:  known = 1'b0;
                        endcase
                end
                `OPC_ADDIU: val = a + sext;
                `OPC_SLTI:  val = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                `OPC_ANDI:  val = a & zext;
                `OPC_ORI:   val = a | zext;
                `OPC_XORI:  val = a ^ zext;
                `OPC_LUI:   val = {inst[15:0], 16'h0};
                default:    known = 1'b0;
                endcase
                if (known && dst != 5'd0) begin
                        mregs[dst] = val;
                        exp_addr.push_back(dst);
                        exp_data.push_back(val);
                end
        endtask

        task automatic check_retire();
                core_pkg::reg_idx_t addr;
                core_pkg::word_t    data;
                if (wb_we_o) begin
                        assert (exp_addr.size() != 0)
                        else report_failure($sformatf("an unexpected write to r%0d retired at %0t",
                                wb_addr_o, $time));
                        addr = exp_addr.pop_front();
                        data = exp_data.pop_front();
                        assert (wb_addr_o == addr)
                        else report_failure($sformatf(
                                "Mismatch at %0t: wb_addr_o = %0d, expected %0d",
                                $time, wb_addr_o, addr));
                        assert (wb_data_o == data)
                        else report_failure($sformatf(
                                "Mismatch at %0t: wb_data_o = %h, expected %h",
                                $time, wb_data_o, data));
                end
        endtask

        initial begin
                clk           = 1'b0;
                lfsr_q        = 32'hbe48_b1a3;
                fetch_ptr     = '0;
                fetched       = 0;
                cycles        = 0;
                rst_n         <= 1'b0;
                ibus_stall_i  <= 1'b1;
                ibus_rddata_i <= '0;
                for (int i = 0; i < `CORE_NREGS; i++) begin
                        mregs[i] = '0;
                end

                repeat (2) @(posedge clk);
                assert (!wb_we_o)
                else report_failure($sformatf("Mismatch at %0t: wb_we_o = %b, expected 0",
                        $time, wb_we_o));
                rst_n <= 1'b1;
                cur_inst = gen_inst(fetch_ptr);
                ibus_rddata_i <= cur_inst;
                ibus_stall_i  <= draw_stall();

                while (fetched < NUM_INSTS) begin
                        @(posedge clk);
                        cycles++;
                        assert (cycles <= TIMEOUT_CYCLES)
                        else report_failure($sformatf(
                                "timeout after %0d cycles, %0d of %0d fetched",
                                cycles, fetched, NUM_INSTS));
                        check_retire();
                        // the bus is read in every cycle from the first edge after reset.
                        if (cycles > 1) begin
                                assert (ibus_read_o)
                                else report_failure($sformatf(
                                        "Mismatch at %0t: ibus_read_o = %b, expected 1",
                                        $time, ibus_read_o));
                        end
                        // the word on the bus is taken at this edge.
                        if (ibus_read_o && !ibus_stall_i) begin
                                assert (ibus_addr_o == fetch_ptr)
                                else report_failure($sformatf(
                                        "Mismatch at %0t: ibus_addr_o = %h, expected %h",
                                        $time, ibus_addr_o, fetch_ptr));
                                model_exec(cur_inst);
                                fetch_ptr = fetch_ptr + 32'd4;
                                fetched++;
                                if (fetched < NUM_INSTS) begin
                                        cur_inst = gen_inst(fetch_ptr);
                                end
                        end
                        ibus_rddata_i <= cur_inst;
                        ibus_stall_i  <= (fetched >= NUM_INSTS) ? 1'b1 : draw_stall();
                end

                // last word retires three edges after it was taken.
                repeat (3) begin
                        @(posedge clk);
                        check_retire();
                end

                if (exp_addr.size() == 0) begin
                        $display("Test completed successfully");
                        $finish;
                end else begin
                        report_failure($sformatf(
                                "writes went missing: %0d expected writes never retired",
                                exp_addr.size()));
                end
        end

endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/inst_decode.sv
rtl/operand_fetch.sv
rtl/alu_exec.sv
rtl/alu_core.sv
sim/tb_alu_core.sv
